/* src/mc_pkg.sv */
`default_nettype none

package mc_pkg;

   // -------------------------------------------------------------------------
   // widths with a meaning of their own

   // host byte address, bit 12 picks the control region
   typedef logic [12:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  strb_t;
   // memory word index, address bits 11:2
   typedef logic [9:0]  word_addr_t;
   // byte offset inside the control window
   typedef logic [3:0]  csr_ofs_t;
   typedef logic [1:0]  resp_t;
   typedef logic [63:0] counter_t;

   // host controller states, one transaction in flight
   typedef enum logic [2:0] {
      HOST_IDLE     = 3'd0,
      HOST_WR_ISSUE = 3'd1,
      HOST_WR_RESP  = 3'd2,
      HOST_RD_ISSUE = 3'd3,
      HOST_RD_RESP  = 3'd4
   } host_state_e;

   // -------------------------------------------------------------------------
   // AXI response codes and address map
   localparam resp_t AXI_RESP_OKAY   = 2'd0;
   localparam resp_t AXI_RESP_SLVERR = 2'd2;

   localparam int CSR_SEL_BIT = 12;
   localparam int WORD_MSB    = 11;
   localparam int WORD_LSB    = 2;

   // counter words are read-only, the tag is read/write
   localparam csr_ofs_t CSR_CTR_LO   = 4'h0;
   localparam csr_ofs_t CSR_CTR_HI   = 4'h4;
   localparam csr_ofs_t CSR_STAT_TAG = 4'h8;
   localparam csr_ofs_t CSR_STAT_CNT = 4'hC;

endpackage

`default_nettype wire

/* src/mc_links.sv */
`default_nettype none

// host controller to bank array
// no ready, the banks take a request every cycle
interface mem_link_if;
   logic               req_v;
   logic               we;
   mc_pkg::word_addr_t word_addr;
   mc_pkg::data_t      wdata;
   mc_pkg::strb_t      wstrb;
   // rsp_v follows req_v by one cycle
   logic               rsp_v;
   mc_pkg::data_t      rdata;

   modport ctrl (output req_v, we, word_addr, wdata, wstrb, input rsp_v, rdata);
   modport mem (input req_v, we, word_addr, wdata, wstrb, output rsp_v, rdata);
endinterface

// host controller to stat unit
interface csr_link_if;
   logic             req_v;
   logic             we;
   mc_pkg::csr_ofs_t ofs;
   mc_pkg::data_t    wdata;
   // response one cycle after the request
   logic             rsp_v;
   mc_pkg::data_t    rdata;
   // unknown offset or write to a read-only register
   logic             err;

   modport ctrl (output req_v, we, ofs, wdata, input rsp_v, rdata, err);
   modport stat (input req_v, we, ofs, wdata, output rsp_v, rdata, err);
endinterface

`default_nettype wire

/* src/mc_host_ctrl.sv */
`default_nettype none

module mc_host_ctrl (
   input  logic          core_clk,
   input  logic          rst_i,
   // AW
   input  mc_pkg::addr_t awaddr_i,
   input  logic          awvalid_i,
   output logic          awready_o,
   // W
   input  mc_pkg::data_t wdata_i,
   input  mc_pkg::strb_t wstrb_i,
   input  logic          wvalid_i,
   output logic          wready_o,
   // B
   output mc_pkg::resp_t bresp_o,
   output logic          bvalid_o,
   input  logic          bready_i,
   // AR
   input  mc_pkg::addr_t araddr_i,
   input  logic          arvalid_i,
   output logic          arready_o,
   // R
   output mc_pkg::data_t rdata_o,
   output mc_pkg::resp_t rresp_o,
   output logic          rvalid_o,
   input  logic          rready_i,
   mem_link_if.ctrl      mem_o,
   csr_link_if.ctrl      csr_o
);

   localparam int ofs_w_lp = $bits(mc_pkg::csr_ofs_t);

   mc_pkg::host_state_e state_q;
   mc_pkg::host_state_e state_d;
   mc_pkg::addr_t       addr_q;
   mc_pkg::data_t       wdata_q;
   mc_pkg::strb_t       wstrb_q;
   mc_pkg::resp_t       resp_q;
   mc_pkg::data_t       rdata_q;
   logic                aw_got_q;
   logic                w_got_q;
   logic                hole_q;
   logic                rsp_q;
   logic                idle;
   logic                aw_fire;
   logic                w_fire;
   logic                ar_fire;
   logic                aw_done;
   logic                w_done;
   logic                issue;
   logic                to_csr;
   logic                in_window;
   logic                rsp_in;
   logic                err_in;
   logic                host_done;

   // -------------------------------------------------------------------------
   // AXI handshakes
   assign idle      = state_q == mc_pkg::HOST_IDLE;
   // a channel that already transferred waits for its partner
   assign awready_o = idle & ~aw_got_q;
   assign wready_o  = idle & ~w_got_q;
   // write side has priority, AR waits while any write part is around
   assign arready_o = idle & ~aw_got_q & ~w_got_q & ~awvalid_i & ~wvalid_i;
   assign aw_fire   = awvalid_i & awready_o;
   assign w_fire    = wvalid_i & wready_o;
   assign ar_fire   = arvalid_i & arready_o;
   assign aw_done   = aw_got_q | aw_fire;
   assign w_done    = w_got_q | w_fire;

   // -------------------------------------------------------------------------
   // region decode and request issue
   assign issue     = (state_q == mc_pkg::HOST_WR_ISSUE) | (state_q == mc_pkg::HOST_RD_ISSUE);
   assign to_csr    = addr_q[mc_pkg::CSR_SEL_BIT];
   // control region is a 16 byte window, the rest of it is a hole
   assign in_window = addr_q[mc_pkg::CSR_SEL_BIT-1:ofs_w_lp] == '0;

   assign mem_o.req_v     = issue & ~to_csr;
   assign mem_o.we        = state_q == mc_pkg::HOST_WR_ISSUE;
   assign mem_o.word_addr = addr_q[mc_pkg::WORD_MSB:mc_pkg::WORD_LSB];
   assign mem_o.wdata     = wdata_q;
   assign mem_o.wstrb     = wstrb_q;

   assign csr_o.req_v = issue & to_csr & in_window;
   assign csr_o.we    = state_q == mc_pkg::HOST_WR_ISSUE;
   assign csr_o.ofs   = addr_q[ofs_w_lp-1:0];
   assign csr_o.wdata = wdata_q;

   // hole answers itself one cycle later, same as the real targets
   assign rsp_in    = mem_o.rsp_v | csr_o.rsp_v | hole_q;
   assign err_in    = (csr_o.rsp_v & csr_o.err) | hole_q;
   assign host_done = (bvalid_o & bready_i) | (rvalid_o & rready_i);

   // -------------------------------------------------------------------------
   // state machine
   always_comb begin
      state_d = state_q;
      case (state_q)
         mc_pkg::HOST_IDLE: begin
            if (aw_done && w_done) begin
               state_d = mc_pkg::HOST_WR_ISSUE;
            end else if (ar_fire) begin
               state_d = mc_pkg::HOST_RD_ISSUE;
            end
         end
         mc_pkg::HOST_WR_ISSUE: state_d = mc_pkg::HOST_WR_RESP;
         mc_pkg::HOST_RD_ISSUE: state_d = mc_pkg::HOST_RD_RESP;
         // stay here under back-pressure
         mc_pkg::HOST_WR_RESP: begin
            if (rsp_q && bready_i) begin
               state_d = mc_pkg::HOST_IDLE;
            end
         end
         mc_pkg::HOST_RD_RESP: begin
            if (rsp_q && rready_i) begin
               state_d = mc_pkg::HOST_IDLE;
            end
         end
         default: state_d = mc_pkg::HOST_IDLE;
      endcase
   end

   always_ff @(posedge core_clk) begin
      if (rst_i) begin
         state_q  <= mc_pkg::HOST_IDLE;
         aw_got_q <= 1'b0;
         w_got_q  <= 1'b0;
         hole_q   <= 1'b0;
         rsp_q    <= 1'b0;
      end else begin
         state_q  <= state_d;
         // both flags drop once the pair is complete
         aw_got_q <= aw_done & ~w_done;
         w_got_q  <= w_done & ~aw_done;
         hole_q   <= issue & to_csr & ~in_window;
         rsp_q    <= rsp_in | (rsp_q & ~host_done);
      end
   end

   // latched request and response payload
   always_ff @(posedge core_clk) begin
      if (aw_fire) begin
         addr_q <= awaddr_i;
      end else if (ar_fire) begin
         addr_q <= araddr_i;
      end
      if (w_fire) begin
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
      if (rsp_in) begin
         resp_q <= err_in ? mc_pkg::AXI_RESP_SLVERR : mc_pkg::AXI_RESP_OKAY;
         // error reads return zero
         if (err_in) begin
            rdata_q <= '0;
         end else if (csr_o.rsp_v) begin
            rdata_q <= csr_o.rdata;
         end else begin
            rdata_q <= mem_o.rdata;
         end
      end
   end

   assign bvalid_o = rsp_q & (state_q == mc_pkg::HOST_WR_RESP);
   assign rvalid_o = rsp_q & (state_q == mc_pkg::HOST_RD_RESP);
   assign bresp_o  = resp_q;
   assign rresp_o  = resp_q;
   assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* src/mc_bank_array.sv */
`default_nettype none

module mc_bank_array #(
   parameter int num_banks_p = 4
) (
   input logic     core_clk,
   mem_link_if.mem mem_i
);

   localparam int idx_w_lp    = $bits(mc_pkg::word_addr_t);
   localparam int lg_banks_lp = $clog2(num_banks_p);
   // keep the select at least one bit wide for a single bank
   localparam int sel_w_lp    = (lg_banks_lp > 0) ? lg_banks_lp : 1;
   localparam int row_w_lp    = idx_w_lp - lg_banks_lp;
   localparam int rows_lp     = (2 ** idx_w_lp) / num_banks_p;
   localparam int strb_w_lp   = $bits(mc_pkg::strb_t);

   logic [sel_w_lp-1:0] bank_sel;
   logic [sel_w_lp-1:0] bank_sel_q;
   logic [row_w_lp-1:0] row;
   mc_pkg::data_t       bank_rdata [num_banks_p];
   logic                rsp_v_q;

   // low index bits pick the bank, so neighbouring words land in
   // neighbouring banks
   assign bank_sel = sel_w_lp'(mem_i.word_addr % num_banks_p);
   assign row      = row_w_lp'(mem_i.word_addr >> lg_banks_lp);

   // -------------------------------------------------------------------------
   // banks
   for (genvar b = 0; b < num_banks_p; b++) begin : g_bank
      mc_pkg::data_t mem_q [rows_lp];
      mc_pkg::data_t rd_q;
      logic          hit;

      assign hit = mem_i.req_v & (bank_sel == sel_w_lp'(b));

      always_ff @(posedge core_clk) begin
         // byte lanes written one by one under wstrb
         if (hit && mem_i.we) begin
            for (int i = 0; i < strb_w_lp; i++) begin
               if (mem_i.wstrb[i]) begin
                  mem_q[row][8*i +: 8] <= mem_i.wdata[8*i +: 8];
               end
            end
         end
         if (hit && !mem_i.we) begin
            rd_q <= mem_q[row];
         end
      end

      assign bank_rdata[b] = rd_q;
   end

   // fixed one cycle latency, bank select follows the data
   always_ff @(posedge core_clk) begin
      rsp_v_q    <= mem_i.req_v;
      bank_sel_q <= bank_sel;
   end

   assign mem_i.rsp_v = rsp_v_q;
   assign mem_i.rdata = bank_rdata[bank_sel_q];

endmodule

`default_nettype wire

/* src/mc_stat_unit.sv */
`default_nettype none

module mc_stat_unit #(
   parameter int reset_depth_p = 2
) (
   input logic      core_clk,
   input logic      rst_i,
   csr_link_if.stat csr_i
);

   localparam int dw_lp = $bits(mc_pkg::data_t);

   logic [reset_depth_p-1:0] rst_chain;
   mc_pkg::counter_t         ctr_q;
   mc_pkg::data_t            tag_q;
   mc_pkg::data_t            tag_cnt_q;
   mc_pkg::data_t            rd_data;
   mc_pkg::data_t            rdata_q;
   logic                     known;
   logic                     read_only;
   logic                     bad;
   logic                     rsp_v_q;
   logic                     err_q;

   // -------------------------------------------------------------------------
   // reset delay chain and global cycle counter
   always_ff @(posedge core_clk) begin
      rst_chain[0] <= rst_i;
   end

   for (genvar i = 1; i < reset_depth_p; i++) begin : g_rst_chain
      always_ff @(posedge core_clk) begin
         rst_chain[i] <= rst_chain[i-1];
      end
   end

   // held at zero until the delayed reset drops
   always_ff @(posedge core_clk) begin
      if (rst_chain[reset_depth_p-1]) begin
         ctr_q <= '0;
      end else begin
         ctr_q <= ctr_q + 1'b1;
      end
   end

   // -------------------------------------------------------------------------
   // offset decode
   always_comb begin
      rd_data   = '0;
      known     = 1'b1;
      read_only = 1'b1;
      case (csr_i.ofs)
         mc_pkg::CSR_CTR_LO:   rd_data = ctr_q[dw_lp-1:0];
         mc_pkg::CSR_CTR_HI:   rd_data = ctr_q[2*dw_lp-1:dw_lp];
         mc_pkg::CSR_STAT_TAG: begin
            rd_data   = tag_q;
            read_only = 1'b0;
         end
         mc_pkg::CSR_STAT_CNT: rd_data = tag_cnt_q;
         default:              known = 1'b0;
      endcase
   end

   assign bad = ~known | (csr_i.we & read_only);

   // print-stat snoop, a rejected write leaves tag and count alone
   always_ff @(posedge core_clk) begin
      if (rst_i) begin
         tag_q     <= '0;
         tag_cnt_q <= '0;
         rsp_v_q   <= 1'b0;
      end else begin
         rsp_v_q <= csr_i.req_v;
         if (csr_i.req_v && csr_i.we && !bad) begin
            tag_q     <= csr_i.wdata;
            tag_cnt_q <= tag_cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge core_clk) begin
      rdata_q <= rd_data;
      err_q   <= bad;
   end

   assign csr_i.rsp_v = rsp_v_q;
   assign csr_i.rdata = rdata_q;
   assign csr_i.err   = err_q;

endmodule

`default_nettype wire

/* src/mc_top.sv */
`default_nettype none

module mc_top #(
   parameter int num_banks_p   = 4,
   parameter int reset_depth_p = 2
) (
   input  logic          core_clk,
   input  logic          rst_i,
   // AXI4-Lite write address
   input  mc_pkg::addr_t awaddr_i,
   input  logic          awvalid_i,
   output logic          awready_o,
   // write data
   input  mc_pkg::data_t wdata_i,
   input  mc_pkg::strb_t wstrb_i,
   input  logic          wvalid_i,
   output logic          wready_o,
   // write response
   output mc_pkg::resp_t bresp_o,
   output logic          bvalid_o,
   input  logic          bready_i,
   // read address
   input  mc_pkg::addr_t araddr_i,
   input  logic          arvalid_i,
   output logic          arready_o,
   // read data
   output mc_pkg::data_t rdata_o,
   output mc_pkg::resp_t rresp_o,
   output logic          rvalid_o,
   input  logic          rready_i
);

   mem_link_if mem_link ();
   csr_link_if csr_link ();

   // AXI slave, decodes memory vs control region
   mc_host_ctrl host_ctrl_i (
      .core_clk  (core_clk),
      .rst_i     (rst_i),
      .awaddr_i  (awaddr_i),
      .awvalid_i (awvalid_i),
      .awready_o (awready_o),
      .wdata_i   (wdata_i),
      .wstrb_i   (wstrb_i),
      .wvalid_i  (wvalid_i),
      .wready_o  (wready_o),
      .bresp_o   (bresp_o),
      .bvalid_o  (bvalid_o),
      .bready_i  (bready_i),
      .araddr_i  (araddr_i),
      .arvalid_i (arvalid_i),
      .arready_o (arready_o),
      .rdata_o   (rdata_o),
      .rresp_o   (rresp_o),
      .rvalid_o  (rvalid_o),
      .rready_i  (rready_i),
      .mem_o     (mem_link.ctrl),
      .csr_o     (csr_link.ctrl)
   );

   mc_bank_array #(
      .num_banks_p (num_banks_p)
   ) bank_array_i (
      .core_clk (core_clk),
      .mem_i    (mem_link.mem)
   );

   // counter, its reset chain and the print-stat registers
   mc_stat_unit #(
      .reset_depth_p (reset_depth_p)
   ) stat_unit_i (
      .core_clk (core_clk),
      .rst_i    (rst_i),
      .csr_i    (csr_link.stat)
   );

endmodule

`default_nettype wire

/* dv/mc_tb_assert.sv */
`default_nettype none

module mc_tb_assert (
   input logic          core_clk,
   input logic          rst_i,
   input mc_pkg::resp_t bresp_o,
   input logic          bvalid_o,
   input logic          bready_i,
   input mc_pkg::data_t rdata_o,
   input mc_pkg::resp_t rresp_o,
   input logic          rvalid_o,
   input logic          rready_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // -------------------------------------------------------------------------
   // no response left over from before reset
   resp_low_after_reset: assert property (@(posedge core_clk)
      $fell(rst_i) |-> !bvalid_o && !rvalid_o)
      else $error("response valid on the first cycle after reset");

   // stalled channels keep valid and payload
   b_hold: assert property (@(posedge core_clk) disable iff (rst_i)
      bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
      else $error("write response changed while stalled");

   r_hold: assert property (@(posedge core_clk) disable iff (rst_i)
      rvalid_o && !rready_i |=> rvalid_o && $stable(rresp_o) && $stable(rdata_o))
      else $error("read response changed while stalled");

endmodule

bind mc_top mc_tb_assert assert_i (.*);

`default_nettype wire

/* dv/mc_tb.sv */
`default_nettype none

module mc_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int banks_lp   = 4;
   localparam int words_lp   = 1024;
   localparam int timeout_lp = 100;

   // one expected B or R beat
   typedef struct packed {
      logic          is_read;
      logic          chk_data;
      mc_pkg::resp_t resp;
      mc_pkg::data_t data;
   } expect_t;

   logic          core_clk = 1'b0;
   logic          rst_i;
   mc_pkg::addr_t awaddr_i;
   logic          awvalid_i;
   logic          awready_o;
   mc_pkg::data_t wdata_i;
   mc_pkg::strb_t wstrb_i;
   logic          wvalid_i;
   logic          wready_o;
   mc_pkg::resp_t bresp_o;
   logic          bvalid_o;
   logic          bready_i;
   mc_pkg::addr_t araddr_i;
   logic          arvalid_i;
   logic          arready_o;
   mc_pkg::data_t rdata_o;
   mc_pkg::resp_t rresp_o;
   logic          rvalid_o;
   logic          rready_i;

   // model state is the memory image, stat tag and tag write count
   mc_pkg::data_t mem_m [words_lp];
   mc_pkg::data_t tag_m;
   mc_pkg::data_t cnt_m;
   expect_t       exp_q [$];
   expect_t       exp_now;
   int            err_cnt;
   int            chk_cnt;
   int            test_err;
   string         test_name;

   always #10 core_clk = ~core_clk;

   mc_top dut_i (.*);

   // -------------------------------------------------------------------------
   // reference model and checks

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
      chk_cnt++;
      if (exp !== act) begin
         $display("error %0t %s expected %h actual %h", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   // expected response for one request against the model state
   function automatic expect_t predict_response(
      input mc_pkg::data_t mem_img [words_lp],
      input mc_pkg::data_t tag,
      input mc_pkg::data_t cnt,
      input logic          rd,
      input mc_pkg::addr_t addr
   );
      expect_t e;
      e.is_read  = rd;
      e.chk_data = rd;
      e.resp     = mc_pkg::AXI_RESP_OKAY;
      e.data     = '0;
      if (!addr[mc_pkg::CSR_SEL_BIT]) begin
         // memory region word index comes from bits 11:2
         e.data = mem_img[addr[11:2]];
      end else if (addr[11:4] != '0) begin
         // beyond the 16 byte control window
         e.resp = mc_pkg::AXI_RESP_SLVERR;
      end else begin
         case (addr[3:0])
            mc_pkg::CSR_CTR_LO: begin
               // free running counter is judged by its trend
               e.chk_data = 1'b0;
               if (!rd) begin
                  e.resp = mc_pkg::AXI_RESP_SLVERR;
               end
            end
            mc_pkg::CSR_CTR_HI: begin
               if (!rd) begin
                  e.resp = mc_pkg::AXI_RESP_SLVERR;
               end
            end
            mc_pkg::CSR_STAT_TAG: e.data = tag;
            mc_pkg::CSR_STAT_CNT: begin
               e.data = cnt;
               if (!rd) begin
                  e.resp = mc_pkg::AXI_RESP_SLVERR;
               end
            end
            default: e.resp = mc_pkg::AXI_RESP_SLVERR;
         endcase
      end
      return e;
   endfunction

   // a rejected write leaves the model alone
   task automatic update_model(input mc_pkg::addr_t addr, input mc_pkg::data_t d,
                               input mc_pkg::strb_t s, input expect_t e);
      if (e.resp != mc_pkg::AXI_RESP_OKAY) begin
         return;
      end
      if (!addr[mc_pkg::CSR_SEL_BIT]) begin
         for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
               mem_m[addr[11:2]][8*i +: 8] = d[8*i +: 8];
            end
         end
      end else if (addr[3:0] == mc_pkg::CSR_STAT_TAG) begin
         tag_m = d;
         cnt_m++;
      end
   endtask

   function automatic mc_pkg::addr_t csr_addr(input mc_pkg::csr_ofs_t ofs);
      return mc_pkg::addr_t'(1 << mc_pkg::CSR_SEL_BIT) | mc_pkg::addr_t'(ofs);
   endfunction

   // response checker takes one expectation per B or R handshake
   always @(posedge core_clk) begin
      if (!rst_i && ((bvalid_o && bready_i) || (rvalid_o && rready_i))) begin
         if (exp_q.size() == 0) begin
            $display("response at %0t arrived with no request outstanding", $time);
            err_cnt++;
         end else begin
            exp_now = exp_q.pop_front();
            compare("rvalid_o", exp_now.is_read, rvalid_o);
            if (exp_now.is_read) begin
               compare("rresp_o", exp_now.resp, rresp_o);
               if (exp_now.chk_data) begin
                  compare("rdata_o", exp_now.data, rdata_o);
               end
            end else begin
               compare("bresp_o", exp_now.resp, bresp_o);
            end
         end
      end
   end

   // -------------------------------------------------------------------------
   // bus driving

   // waits for B or R and keeps ready low for hold cycles once valid shows
   task automatic collect_response(input bit rd, input int hold,
                                   output mc_pkg::data_t rdata);
      int            t;
      mc_pkg::resp_t resp_snap;
      mc_pkg::data_t data_snap;
      t     = 0;
      rdata = '0;
      do begin
         @(posedge core_clk);
         t++;
      end while (!(rd ? rvalid_o : bvalid_o) && t < timeout_lp);
      if (!(rd ? rvalid_o : bvalid_o)) begin
         $display("timeout waiting for the %s response", rd ? "read" : "write");
         err_cnt++;
         bready_i <= 1'b1;
         rready_i <= 1'b1;
         return;
      end
      resp_snap = rd ? rresp_o : bresp_o;
      data_snap = rdata_o;
      for (int i = 0; i < hold; i++) begin
         if (i == hold - 1) begin
            bready_i <= 1'b1;
            rready_i <= 1'b1;
         end
         @(posedge core_clk);
         compare(rd ? "rvalid_o" : "bvalid_o", 1'b1, rd ? rvalid_o : bvalid_o);
         compare(rd ? "rresp_o" : "bresp_o", resp_snap, rd ? rresp_o : bresp_o);
         if (rd) begin
            compare("rdata_o", data_snap, rdata_o);
         end
      end
      rdata = rdata_o;
   endtask

   // AW and W go in random order, either together or one before the other
   task automatic write_word(input mc_pkg::addr_t addr, input mc_pkg::data_t d,
                             input mc_pkg::strb_t s, input int hold);
      expect_t       e;
      int            order;
      int            t;
      bit            aw_ok;
      bit            w_ok;
      mc_pkg::data_t unused;
      e = predict_response(mem_m, tag_m, cnt_m, 1'b0, addr);
      exp_q.push_back(e);
      update_model(addr, d, s, e);
      order = $urandom_range(2);
      @(posedge core_clk);
      awaddr_i  <= addr;
      wdata_i   <= d;
      wstrb_i   <= s;
      awvalid_i <= (order != 2);
      wvalid_i  <= (order != 1);
      bready_i  <= (hold == 0);
      aw_ok = 1'b0;
      w_ok  = 1'b0;
      t     = 0;
      while (!(aw_ok && w_ok) && t < timeout_lp) begin
         @(posedge core_clk);
         t++;
         if (awvalid_i && awready_o) begin
            aw_ok = 1'b1;
            awvalid_i <= 1'b0;
         end
         if (wvalid_i && wready_o) begin
            w_ok = 1'b1;
            wvalid_i <= 1'b0;
         end
         // the later channel comes up once the first one went through
         if (aw_ok && !w_ok) begin
            wvalid_i <= 1'b1;
         end
         if (w_ok && !aw_ok) begin
            awvalid_i <= 1'b1;
         end
      end
      if (!(aw_ok && w_ok)) begin
         $display("timeout waiting for the write address and data handshakes");
         err_cnt++;
         awvalid_i <= 1'b0;
         wvalid_i  <= 1'b0;
         bready_i  <= 1'b1;
         return;
      end
      collect_response(1'b0, hold, unused);
   endtask

   task automatic read_word(input mc_pkg::addr_t addr, input int hold,
                            output mc_pkg::data_t rdata);
      expect_t e;
      int      t;
      bit      ok;
      e = predict_response(mem_m, tag_m, cnt_m, 1'b1, addr);
      exp_q.push_back(e);
      rdata = '0;
      @(posedge core_clk);
      araddr_i  <= addr;
      arvalid_i <= 1'b1;
      rready_i  <= (hold == 0);
      ok = 1'b0;
      t  = 0;
      while (!ok && t < timeout_lp) begin
         @(posedge core_clk);
         t++;
         if (arvalid_i && arready_o) begin
            ok = 1'b1;
            arvalid_i <= 1'b0;
         end
      end
      if (!ok) begin
         $display("timeout waiting for the read address handshake");
         err_cnt++;
         arvalid_i <= 1'b0;
         rready_i  <= 1'b1;
         return;
      end
      collect_response(1'b1, hold, rdata);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err  = err_cnt;
   endtask

   task automatic end_test();
      $display("test %s done, %0d mismatches", test_name, err_cnt - test_err);
   endtask

   // -------------------------------------------------------------------------
   // test sequence

   initial begin : main_seq
      mc_pkg::addr_t addrs [16];
      mc_pkg::data_t d0;
      mc_pkg::data_t d1;
      void'($urandom(61676));
      rst_i     = 1'b1;
      awaddr_i  = '0;
      awvalid_i = 1'b0;
      wdata_i   = '0;
      wstrb_i   = '0;
      wvalid_i  = 1'b0;
      bready_i  = 1'b1;
      araddr_i  = '0;
      arvalid_i = 1'b0;
      rready_i  = 1'b1;
      tag_m     = '0;
      cnt_m     = '0;
      err_cnt   = 0;
      chk_cnt   = 0;

      start_test("reset");
      @(posedge core_clk);
      @(posedge core_clk);
      compare("bvalid_o", 1'b0, bvalid_o);
      compare("rvalid_o", 1'b0, rvalid_o);
      rst_i <= 1'b0;
      @(posedge core_clk);
      compare("bvalid_o", 1'b0, bvalid_o);
      compare("rvalid_o", 1'b0, rvalid_o);
      compare("awready_o", 1'b1, awready_o);
      compare("wready_o", 1'b1, wready_o);
      compare("arready_o", 1'b1, arready_o);
      end_test();

      // full words first so later partial strobes never meet unknown bytes
      start_test("memory");
      for (int i = 0; i < 16; i++) begin
         addrs[i] = {1'b0, 8'($urandom), 2'(i % banks_lp), 2'b00};
         write_word(addrs[i], $urandom, 4'hF, 0);
      end
      for (int i = 0; i < 16; i++) begin
         write_word(addrs[$urandom_range(15)], $urandom, 4'($urandom), 0);
      end
      for (int i = 0; i < 16; i++) begin
         read_word(addrs[i], 0, d0);
      end
      end_test();

      start_test("back-pressure");
      write_word(addrs[0], $urandom, 4'hF, $urandom_range(8, 1));
      read_word(addrs[0], $urandom_range(8, 1), d0);
      write_word(addrs[1], $urandom, 4'($urandom), 0);
      read_word(addrs[1], 0, d0);
      end_test();

      start_test("counter");
      read_word(csr_addr(mc_pkg::CSR_CTR_LO), 0, d0);
      repeat (5) @(posedge core_clk);
      read_word(csr_addr(mc_pkg::CSR_CTR_LO), 0, d1);
      chk_cnt++;
      if (d1 <= d0) begin
         $display("global counter did not increase between two reads at %0t", $time);
         err_cnt++;
      end
      read_word(csr_addr(mc_pkg::CSR_CTR_HI), 0, d0);
      end_test();

      start_test("stat snoop");
      repeat (3) begin
         write_word(csr_addr(mc_pkg::CSR_STAT_TAG), $urandom, 4'hF, 0);
         read_word(csr_addr(mc_pkg::CSR_STAT_TAG), 0, d0);
      end
      read_word(csr_addr(mc_pkg::CSR_STAT_CNT), 0, d0);
      end_test();

      start_test("errors");
      read_word(csr_addr(mc_pkg::CSR_CTR_LO) | 13'h010, 0, d0);
      read_word(mc_pkg::addr_t'(13'h1000 | 13'($urandom_range(4095, 16))), 0, d0);
      write_word(csr_addr(mc_pkg::CSR_CTR_LO), $urandom, 4'hF, 0);
      write_word(csr_addr(mc_pkg::CSR_STAT_CNT), $urandom, 4'hF, 0);
      read_word(csr_addr(mc_pkg::CSR_STAT_TAG), 0, d0);
      read_word(csr_addr(mc_pkg::CSR_STAT_CNT), 0, d0);
      read_word(addrs[2], 0, d0);
      end_test();

      repeat (2) @(posedge core_clk);
      if (exp_q.size() != 0) begin
         $display("%0d expected responses never arrived", exp_q.size());
         err_cnt++;
      end
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
src/mc_pkg.sv
src/mc_links.sv
src/mc_host_ctrl.sv
src/mc_bank_array.sv
src/mc_stat_unit.sv
src/mc_top.sv
dv/mc_tb_assert.sv
dv/mc_tb.sv

/* Bender.yml */
package:
  name: mc_complex

sources:
  - src/mc_pkg.sv
  - src/mc_links.sv
  - src/mc_host_ctrl.sv
  - src/mc_bank_array.sv
  - src/mc_stat_unit.sv
  - src/mc_top.sv
  - target: test
    files:
      - dv/mc_tb_assert.sv
      - dv/mc_tb.sv
